/* bigCorePkg.sv */
package bigCorePkg;

    // ==============================
    // Meaningful vector types
    // ==============================
    typedef logic [31:0] wordT;    // Data word, pc or address
    typedef logic [7:0]  byteT;    // One memory byte
    typedef logic [3:0]  byteEnT;  // Per-lane byte enables
    typedef logic [4:0]  regIdxT;  // Register index
    typedef logic [3:0]  aluOpT;   // ALU operation code
    typedef logic [1:0]  wbSelT;   // Write-back source

    // ==============================
    // Memory map
    // ==============================
    localparam int   iMemSize   = 1024;           // Bytes
    localparam int   dMemSize   = 1024;           // Bytes
    localparam wordT dMemOffset = 32'h0000_1000;  // First data byte address
    localparam int   iMemIdxW   = $clog2(iMemSize);
    localparam int   dMemIdxW   = $clog2(dMemSize);

    // ==============================
    // ALU operations
    // ==============================
    localparam aluOpT aluAdd   = 4'd0;
    localparam aluOpT aluSub   = 4'd1;
    localparam aluOpT aluSll   = 4'd2;
    localparam aluOpT aluSlt   = 4'd3;
    localparam aluOpT aluSltu  = 4'd4;
    localparam aluOpT aluXor   = 4'd5;
    localparam aluOpT aluSrl   = 4'd6;
    localparam aluOpT aluSra   = 4'd7;
    localparam aluOpT aluOr    = 4'd8;
    localparam aluOpT aluAnd   = 4'd9;
    localparam aluOpT aluPassB = 4'd10;  // LUI path

    // ==============================
    // RV32I opcodes and funct3 codes
    // ==============================
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    localparam logic [2:0] f3Beq   = 3'b000;
    localparam logic [2:0] f3Bne   = 3'b001;
    localparam logic [2:0] f3Blt   = 3'b100;
    localparam logic [2:0] f3Bge   = 3'b101;
    localparam logic [2:0] f3Bltu  = 3'b110;
    localparam logic [2:0] f3Bgeu  = 3'b111;

    localparam logic [2:0] f3Byte  = 3'b000;  // Load and store widths
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

    localparam wbSelT wbAlu = 2'd0;
    localparam wbSelT wbMem = 2'd1;
    localparam wbSelT wbPc4 = 2'd2;  // Link value of JAL and JALR

endpackage

/* alu.sv */
module alu
import bigCorePkg::*;
(
    input  wordT       opA,
    input  wordT       opB,
    input  aluOpT      aluOp,
    input  logic [2:0] branchFunct,
    output wordT       result,
    output logic       branchTaken
);

logic [4:0] shamt;
logic       isEqual;
logic       isLess;
logic       isLessU;

assign shamt   = opB[4:0];  // RV32I uses the low 5 bits only
assign isEqual = (opA == opB);
assign isLess  = ($signed(opA) < $signed(opB));
assign isLessU = (opA < opB);

// ==============================
// Integer operations
// ==============================
always_comb begin
    case (aluOp)
        aluAdd:   result = opA + opB;
        aluSub:   result = opA - opB;
        aluSll:   result = opA << shamt;
        aluSlt:   result = {31'b0, isLess};
        aluSltu:  result = {31'b0, isLessU};
        aluXor:   result = opA ^ opB;
        aluSrl:   result = opA >> shamt;
        aluSra:   result = wordT'($signed(opA) >>> shamt);
        aluOr:    result = opA | opB;
        aluAnd:   result = opA & opB;
        aluPassB: result = opB;
        default:  result = '0;
    endcase
end

// ==============================
// Branch comparison
// ==============================
always_comb begin
    case (branchFunct)
        f3Beq:   branchTaken = isEqual;
        f3Bne:   branchTaken = !isEqual;
        f3Blt:   branchTaken = isLess;
        f3Bge:   branchTaken = !isLess;
        f3Bltu:  branchTaken = isLessU;
        f3Bgeu:  branchTaken = !isLessU;
        default: branchTaken = 1'b0;  // 010 and 011 are not branches
    endcase
end

endmodule

/* regFile.sv */
module regFile
import bigCorePkg::*;
(
    input  logic   Clk,
    input  logic   arstN,
    input  logic   wrEn,
    input  regIdxT wrIdx,
    input  wordT   wrData,
    input  regIdxT rdIdxA,
    input  regIdxT rdIdxB,
    output wordT   rdDataA,
    output wordT   rdDataB
);

wordT regs [1:31];  // x0 has no storage

always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (wrEn && (wrIdx != '0)) begin
        regs[wrIdx] <= wrData;  // Writes to x0 dropped
    end
end

assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

/* ctrlDecode.sv */
module ctrlDecode
import bigCorePkg::*;
(
    input  wordT       instruction,
    output regIdxT     rs1Idx,
    output regIdxT     rs2Idx,
    output regIdxT     rdIdx,
    output wordT       imm,
    output aluOpT      aluOp,
    output logic       aluSrcImm,
    output logic       aluSrcPc,
    output logic       regWrEn,
    output logic       memRdEn,
    output logic       memWrEn,
    output logic       isBranch,
    output logic       isJal,
    output logic       isJalr,
    output logic [2:0] memFunct,
    output wbSelT      wbSel
);

logic [6:0] opcode;
logic [2:0] funct3;
logic       funct7b5;
wordT       immI;
wordT       immS;
wordT       immB;
wordT       immU;
wordT       immJ;
aluOpT      arithOp;
logic       loadOk;
logic       storeOk;

// ==============================
// Field split and immediates
// ==============================
assign opcode   = instruction[6:0];
assign rdIdx    = instruction[11:7];
assign funct3   = instruction[14:12];
assign rs1Idx   = instruction[19:15];
assign rs2Idx   = instruction[24:20];
assign funct7b5 = instruction[30];  // SUB and SRA select
assign memFunct = funct3;

assign immI = {{20{instruction[31]}}, instruction[31:20]};
assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
               instruction[30:25], instruction[11:8], 1'b0};
assign immU = {instruction[31:12], 12'b0};
assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
               instruction[20], instruction[30:21], 1'b0};

// Only the RV32I widths count as real accesses
assign loadOk  = (funct3 == f3Byte) || (funct3 == f3Half) || (funct3 == f3Word) ||
                 (funct3 == f3ByteU) || (funct3 == f3HalfU);
assign storeOk = (funct3 == f3Byte) || (funct3 == f3Half) || (funct3 == f3Word);

// Register-register and register-immediate ALU op
always_comb begin
    case (funct3)
        3'b000:  arithOp = ((opcode == opOp) && funct7b5) ? aluSub : aluAdd;
        3'b001:  arithOp = aluSll;
        3'b010:  arithOp = aluSlt;
        3'b011:  arithOp = aluSltu;
        3'b100:  arithOp = aluXor;
        3'b101:  arithOp = funct7b5 ? aluSra : aluSrl;  // Also bit 30 for SRAI
        3'b110:  arithOp = aluOr;
        default: arithOp = aluAnd;
    endcase
end

// ==============================
// Control strobes
// ==============================
always_comb begin
    imm       = immI;
    aluOp     = aluAdd;
    aluSrcImm = 1'b0;
    aluSrcPc  = 1'b0;
    regWrEn   = 1'b0;
    memRdEn   = 1'b0;
    memWrEn   = 1'b0;
    isBranch  = 1'b0;
    isJal     = 1'b0;
    isJalr    = 1'b0;
    wbSel     = wbAlu;
    case (opcode)
        opLui: begin
            imm = immU; aluOp = aluPassB; aluSrcImm = 1'b1; regWrEn = 1'b1;
        end
        opAuipc: begin
            imm = immU; aluSrcPc = 1'b1; aluSrcImm = 1'b1; regWrEn = 1'b1;
        end
        opJal: begin
            imm = immJ; isJal = 1'b1; regWrEn = 1'b1; wbSel = wbPc4;
        end
        opJalr: begin
            aluSrcImm = 1'b1; isJalr = 1'b1; regWrEn = 1'b1; wbSel = wbPc4;  // rs1 + immI
        end
        opBranch: begin
            imm = immB; isBranch = 1'b1;  // ALU compares rs1 and rs2
        end
        opLoad: begin
            aluSrcImm = 1'b1; memRdEn = loadOk; regWrEn = loadOk; wbSel = wbMem;
        end
        opStore: begin
            imm = immS; aluSrcImm = 1'b1; memWrEn = storeOk;
        end
        opOpImm: begin
            aluOp = arithOp; aluSrcImm = 1'b1; regWrEn = 1'b1;
        end
        opOp: begin
            aluOp = arithOp; regWrEn = 1'b1;
        end
        default: begin
            regWrEn = 1'b0;  // Unknown opcode runs as a no-op
        end
    endcase
end

endmodule

/* scCore.sv */
module scCore
import bigCorePkg::*;
(
    input  logic   Clk,
    input  logic   arstN,
    input  logic   run,
    input  wordT   instruction,
    input  wordT   dMemRspData,
    output wordT   pc,
    output wordT   dMemAddress,
    output wordT   dMemData,
    output byteEnT dMemByteEn,
    output logic   dMemWrEn,
    output logic   dMemRdEn
);

regIdxT     rs1Idx;
regIdxT     rs2Idx;
regIdxT     rdIdx;
wordT       imm;
aluOpT      aluOp;
logic       aluSrcImm;
logic       aluSrcPc;
logic       regWrEn;
logic       memRdEn;
logic       memWrEn;
logic       isBranch;
logic       isJal;
logic       isJalr;
logic [2:0] memFunct;
wbSelT      wbSel;
wordT       rs1Data;
wordT       rs2Data;
wordT       aluA;
wordT       aluB;
wordT       aluResult;
logic       branchTaken;
wordT       pcPlus4;
wordT       nextPc;
logic [1:0] byteOffset;
logic [4:0] laneShift;
wordT       storeRaw;
byteEnT     storeRawEn;
wordT       loadLane;
wordT       loadData;
wordT       wbData;

ctrlDecode ctrlDecode_i (
    .instruction (instruction),
    .rs1Idx      (rs1Idx),
    .rs2Idx      (rs2Idx),
    .rdIdx       (rdIdx),
    .imm         (imm),
    .aluOp       (aluOp),
    .aluSrcImm   (aluSrcImm),
    .aluSrcPc    (aluSrcPc),
    .regWrEn     (regWrEn),
    .memRdEn     (memRdEn),
    .memWrEn     (memWrEn),
    .isBranch    (isBranch),
    .isJal       (isJal),
    .isJalr      (isJalr),
    .memFunct    (memFunct),
    .wbSel       (wbSel)
);

regFile regFile_i (
    .Clk     (Clk),
    .arstN   (arstN),
    .wrEn    (regWrEn && run),  // No write while halted for loading
    .wrIdx   (rdIdx),
    .wrData  (wbData),
    .rdIdxA  (rs1Idx),
    .rdIdxB  (rs2Idx),
    .rdDataA (rs1Data),
    .rdDataB (rs2Data)
);

assign aluA = aluSrcPc  ? pc  : rs1Data;
assign aluB = aluSrcImm ? imm : rs2Data;

alu alu_i (
    .opA         (aluA),
    .opB         (aluB),
    .aluOp       (aluOp),
    .branchFunct (memFunct),  // Same funct3 field
    .result      (aluResult),
    .branchTaken (branchTaken)
);

// ==============================
// Program counter
// ==============================
assign pcPlus4 = pc + 32'd4;

always_comb begin
    if (isJalr) nextPc = {aluResult[31:1], 1'b0};
    else if (isJal || (isBranch && branchTaken)) nextPc = pc + imm;
    else nextPc = pcPlus4;
end

always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) pc <= '0;
    else if (run) pc <= nextPc;  // Holds during program load
end

// ==============================
// Store lanes and load extension
// ==============================
assign byteOffset  = aluResult[1:0];
assign dMemAddress = aluResult;

always_comb begin
    case (memFunct[1:0])
        2'b00: begin
            laneShift = {byteOffset, 3'b000};
            storeRaw = {24'b0, rs2Data[7:0]};
            storeRawEn = 4'b0001;
        end
        2'b01: begin
            laneShift = {byteOffset[1], 4'b0000};  // Halves stay in one half
            storeRaw = {16'b0, rs2Data[15:0]};
            storeRawEn = 4'b0011;
        end
        default: begin
            laneShift = 5'd0;
            storeRaw = rs2Data;
            storeRawEn = 4'b1111;
        end
    endcase
end

assign dMemData   = storeRaw << laneShift;
assign dMemByteEn = storeRawEn << laneShift[4:3];
assign dMemWrEn   = memWrEn && run;
assign dMemRdEn   = memRdEn;
assign loadLane   = dMemRspData >> laneShift;  // Addressed lane down to bit 0

always_comb begin
    case (memFunct)
        f3Byte:  loadData = {{24{loadLane[7]}}, loadLane[7:0]};
        f3Half:  loadData = {{16{loadLane[15]}}, loadLane[15:0]};
        f3ByteU: loadData = {24'b0, loadLane[7:0]};
        f3HalfU: loadData = {16'b0, loadLane[15:0]};
        default: loadData = loadLane;
    endcase
end

always_comb begin
    case (wbSel)
        wbMem:   wbData = loadData;
        wbPc4:   wbData = pcPlus4;
        default: wbData = aluResult;
    endcase
end

// A jump or branch target must never leave pc off a word boundary
pcAligned: assert property (
    @(posedge Clk) disable iff (!arstN) run |=> (pc[1:0] == 2'b00)
) else $error("pc became misaligned: %h", pc);

endmodule

/* refCore.sv */
module refCore
import bigCorePkg::*;
(
    input  logic   Clk,
    input  logic   arstN,
    input  logic   run,
    input  logic   imemWrEn,
    input  wordT   imemWrAddr,
    input  wordT   imemWrData,
    output wordT   pc,
    output logic   storeEn,
    output wordT   storeAddr,
    output wordT   storeData,
    output byteEnT storeByteEn
);

wordT   instruction;
wordT   dMemAddress;
wordT   dMemData;
byteEnT dMemByteEn;
logic   dMemWrEn;
logic   dMemRdEn;
wordT   dMemRspData;
wordT   dLocalAddr;
byteT   IMem [0:iMemSize-1];
byteT   DMem [0:dMemSize-1];  // Maps dMemOffset onward

logic [iMemIdxW-3:0] iWordSel;
logic [iMemIdxW-1:0] iWrIdx;
logic [dMemIdxW-3:0] dWordSel;

scCore scCore_i (
    .Clk         (Clk),
    .arstN       (arstN),
    .run         (run),
    .instruction (instruction),  // From IMem
    .dMemRspData (dMemRspData),  // From DMem
    .pc          (pc),
    .dMemAddress (dMemAddress),
    .dMemData    (dMemData),
    .dMemByteEn  (dMemByteEn),
    .dMemWrEn    (dMemWrEn),
    .dMemRdEn    (dMemRdEn)
);

// ==============================
// Instruction memory
// ==============================
assign iWordSel = pc[iMemIdxW-1:2];
assign iWrIdx   = imemWrAddr[iMemIdxW-1:0];

assign instruction = {IMem[{iWordSel, 2'd3}], IMem[{iWordSel, 2'd2}],
                      IMem[{iWordSel, 2'd1}], IMem[{iWordSel, 2'd0}]};

always_ff @(posedge Clk) begin
    if (imemWrEn && !run) begin  // Little-endian program load
        IMem[iWrIdx]        <= imemWrData[7:0];
        IMem[iWrIdx + 2'd1] <= imemWrData[15:8];
        IMem[iWrIdx + 2'd2] <= imemWrData[23:16];
        IMem[iWrIdx + 2'd3] <= imemWrData[31:24];
    end
end

// ==============================
// Data memory
// ==============================
assign dLocalAddr = dMemAddress - dMemOffset;
assign dWordSel   = dLocalAddr[dMemIdxW-1:2];

assign dMemRspData = {DMem[{dWordSel, 2'd3}], DMem[{dWordSel, 2'd2}],
                      DMem[{dWordSel, 2'd1}], DMem[{dWordSel, 2'd0}]};

always_ff @(posedge Clk) begin
    if (dMemWrEn) begin
        if (dMemByteEn[0]) DMem[{dWordSel, 2'd0}] <= dMemData[7:0];
        if (dMemByteEn[1]) DMem[{dWordSel, 2'd1}] <= dMemData[15:8];
        if (dMemByteEn[2]) DMem[{dWordSel, 2'd2}] <= dMemData[23:16];
        if (dMemByteEn[3]) DMem[{dWordSel, 2'd3}] <= dMemData[31:24];
    end
end

assign storeEn     = dMemWrEn;  // Observation copies
assign storeAddr   = dMemAddress;
assign storeData   = dMemData;
assign storeByteEn = dMemByteEn;

dAccessInRange: assert property (
    @(posedge Clk) disable iff (!arstN)
    (run && (dMemWrEn || dMemRdEn)) |->
        (dMemAddress >= dMemOffset) && (dMemAddress < dMemOffset + dMemSize)
) else $error("Data access outside DMem: %h", dMemAddress);

iLoadOnlyHalted: assert property (
    @(posedge Clk) disable iff (!arstN) imemWrEn |-> !run
) else $error("Instruction load while the core runs");

endmodule

/* refCoreTb.sv */
module refCoreTb
import bigCorePkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int    halfPeriod  = 20;    // 40 ns clock
localparam int    driveDelay  = 2;     // Inputs change after the rising edge
localparam int    resetCycles = 3;
localparam int    runTimeout  = 2000;  // Cycles allowed to reach the halt loop
localparam int    quietCycles = 4;     // Watch for stray stores after halting
localparam string traceFile   = "coreTrace.txt";

logic   Clk;
logic   arstN;
logic   run;
logic   imemWrEn;
wordT   imemWrAddr;
wordT   imemWrData;
wordT   pc;
logic   storeEn;
wordT   storeAddr;
wordT   storeData;
byteEnT storeByteEn;

wordT   progAddr [$];
wordT   progWord [$];
wordT   expAddr [$];
wordT   expData [$];
byteEnT expEn [$];
wordT   haltAddr;
int     storeIdx;
int     errorCount;
bit     traceOk;
bit     reached;

refCore refCore_i (
    .Clk         (Clk),
    .arstN       (arstN),
    .run         (run),
    .imemWrEn    (imemWrEn),
    .imemWrAddr  (imemWrAddr),
    .imemWrData  (imemWrData),
    .pc          (pc),
    .storeEn     (storeEn),
    .storeAddr   (storeAddr),
    .storeData   (storeData),
    .storeByteEn (storeByteEn)
);

always #(halfPeriod) Clk = ~Clk;

// ==============================
// Trace reading
// ==============================
task automatic readTrace(output bit ok);
    int    fd;
    int    n;
    bit    haveHalt;
    string line;
    byte   tag;
    wordT  a;
    wordT  b;
    wordT  c;
    haveHalt = 1'b0;
    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
        $display("Could not open the trace file %s", traceFile);
    end else begin
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            tag = (n > 0) ? line.getc(0) : 8'h00;
            if (tag == "P") begin
                n = $sscanf(line, "P %h %h", a, b);
                progAddr.push_back(a);
                progWord.push_back(b);
            end else if (tag == "S") begin
                n = $sscanf(line, "S %h %h %h", a, b, c);
                expAddr.push_back(a);
                expData.push_back(b);
                expEn.push_back(c[3:0]);
            end else if (tag == "H") begin
                n = $sscanf(line, "H %h", a);
                haltAddr = a;
                haveHalt = 1'b1;
            end
        end
        $fclose(fd);
        if (!haveHalt || (progAddr.size() == 0)) begin
            $display("The trace file holds no program or no halt address");
        end
    end
    ok = haveHalt && (progAddr.size() > 0);
endtask

// ==============================
// Stimulus
// ==============================
task automatic applyReset();
    repeat (resetCycles) @(posedge Clk);
    #driveDelay;
    arstN = 1'b1;
endtask

task automatic loadProgram();
    for (int i = 0; i < progAddr.size(); i++) begin
        @(posedge Clk);
        #driveDelay;
        imemWrEn   = 1'b1;  // One word per strobe
        imemWrAddr = progAddr[i];
        imemWrData = progWord[i];
    end
    @(posedge Clk);
    #driveDelay;
    imemWrEn = 1'b0;
endtask

task automatic waitForHalt(output bit ok);
    int cycles;
    cycles = 0;
    while ((pc !== haltAddr) && (cycles < runTimeout)) begin
        @(negedge Clk);
        cycles++;
    end
    ok = (pc === haltAddr);
    if (!ok) begin
        $display("Timeout: the core never reached the halt address %h within %0d cycles",
                 haltAddr, runTimeout);
        errorCount++;
    end
endtask

// ==============================
// Store monitor
// ==============================
always @(negedge Clk) begin
    if (arstN) begin
        if (!run) begin
            if ((storeEn !== 1'b0) || (pc !== '0)) begin  // Core must stay idle while loading
                $display("CHECK FAILED at %0t: while loading storeEn=%b pc=%h, expected 0 and 0",
                         $time, storeEn, pc);
                errorCount++;
            end
        end else if (storeEn) begin
            if (storeIdx >= expAddr.size()) begin
                $display("Unexpected store to address %h after the last expected store",
                         storeAddr);
                errorCount++;
            end else begin
                if ((storeAddr !== expAddr[storeIdx]) || (storeData !== expData[storeIdx]) ||
                    (storeByteEn !== expEn[storeIdx])) begin
                    // Values shown as addr/data/byteEn
                    $display("CHECK FAILED at %0t: store %0d expected %h/%h/%h got %h/%h/%h",
                             $time, storeIdx, expAddr[storeIdx], expData[storeIdx],
                             expEn[storeIdx], storeAddr, storeData, storeByteEn);
                    errorCount++;
                end
                storeIdx++;
            end
        end
    end
end

initial begin
    Clk        = 1'b0;
    arstN      = 1'b0;
    run        = 1'b0;
    imemWrEn   = 1'b0;
    imemWrAddr = '0;
    imemWrData = '0;
    storeIdx   = 0;
    errorCount = 0;
    haltAddr   = '0;
    reached    = 1'b0;
    readTrace(traceOk);
    if (!traceOk) begin
        errorCount++;
    end else begin
        applyReset();
        loadProgram();
        @(posedge Clk);
        #driveDelay;
        run = 1'b1;
        waitForHalt(reached);
        if (reached) begin
            repeat (quietCycles) @(negedge Clk);  // Halt loop must not store
            if (storeIdx != expAddr.size()) begin
                $display("Only %0d of %0d expected stores were seen", storeIdx, expAddr.size());
                errorCount++;
            end
        end
    end
    $display("Stores checked: %0d of %0d, errors: %0d", storeIdx, expAddr.size(), errorCount);
    if (errorCount == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

/* coreTrace.txt */
# P <byte address> <instruction word>   program words, loaded before run rises
# S <address> <lane-placed data> <byte enables>   expected stores in order, H <halt address>
P 00000000 00001537  # lui  x10, 0x1
P 00000004 F9C00093  # addi x1, x0, -100
P 00000008 00300113  # addi x2, x0, 3
P 0000000C 402081B3  # sub  x3, x1, x2
P 00000010 00352023
P 00000014 4020D233  # sra  x4, x1, x2
P 00000018 00452223
P 0000001C 0020D2B3  # srl  x5, x1, x2
P 00000020 00552423
P 00000024 0020A333  # slt  x6, x1, x2
P 00000028 0020B3B3  # sltu x7, x1, x2
P 0000002C 00431313  # slli x6, x6, 4
P 00000030 00736433  # or   x8, x6, x7
P 00000034 003444B3  # xor  x9, x8, x3
P 00000038 0F04F493  # andi x9, x9, 0xf0
P 0000003C 00952623
P 00000040 A1B2C637  # x12 = a1b2c3d4
P 00000044 3D460613
P 00000048 00C50823  # sb at each offset
P 0000004C 00C508A3
P 00000050 00C50923
P 00000054 00C509A3
P 00000058 00C51A23  # sh at both halves
P 0000005C 00C51B23
P 00000060 01150683  # lb   x13, 17(x10)
P 00000064 00D52C23
P 00000068 01554703  # lbu  x14, 21(x10)
P 0000006C 00E52E23
P 00000070 01651783  # lh   x15, 22(x10)
P 00000074 02F52023
P 00000078 01455803  # lhu  x16, 20(x10)
P 0000007C 03052223
P 00000080 01052883  # lw   x17, 16(x10)
P 00000084 03152423
# Each branch kind: not-taken form, taken form, then a store that must be skipped
P 00000088 00208463
P 0000008C 00210463
P 00000090 02052623
P 00000094 00211463
P 00000098 00209463
P 0000009C 02052623
P 000000A0 00114463
P 000000A4 0020C463
P 000000A8 02052623
P 000000AC 0020D463
P 000000B0 00115463
P 000000B4 02052623
P 000000B8 0020E463
P 000000BC 00116463
P 000000C0 02052623
P 000000C4 00117463
P 000000C8 0020F463
P 000000CC 02052623
P 000000D0 00800AEF  # jal  x21, +8
P 000000D4 02052623
P 000000D8 03552823
P 000000DC 011A8BE7  # jalr x23, 17(x21) lands on e4
P 000000E0 02052623
P 000000E4 03752A23
P 000000E8 00001C17  # auipc x24, 0x1
P 000000EC 03852C23
P 000000F0 0000006F  # jal x0, 0
S 00001000 FFFFFF99 F
S 00001004 FFFFFFF3 F
S 00001008 1FFFFFF3 F
S 0000100C 00000080 F
S 00001010 000000D4 1
S 00001011 0000D400 2
S 00001012 00D40000 4
S 00001013 D4000000 8
S 00001014 0000C3D4 3
S 00001016 C3D40000 C
S 00001018 FFFFFFD4 F
S 0000101C 000000C3 F
S 00001020 FFFFC3D4 F
S 00001024 0000C3D4 F
S 00001028 D4D4D4D4 F
S 00001030 000000D4 F
S 00001034 000000E0 F
S 00001038 000010E8 F
H 000000F0

/* compile.f */
bigCorePkg.sv
alu.sv
regFile.sv
ctrlDecode.sv
scCore.sv
refCore.sv
refCoreTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build the refCore testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBinary=refCoreTbSim
logFile=sim.log

verilator --binary --assert -f compile.f --top-module refCoreTb \
    -Mdir "$buildDir" -o "$simBinary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$logFile"; then
    exit 1
fi
exit 0
